/* rtl/rvPkg.sv */
package rvPkg;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OpRType  = 7'b0110011, // register-register alu
        OpIType  = 7'b0010011, // register-immediate alu
        OpLoad   = 7'b0000011, // lw only
        OpStore  = 7'b0100011, // sw only
        OpBranch = 7'b1100011, // beq .. bgeu
        OpJal    = 7'b1101111,
        OpJalr   = 7'b1100111,
        OpLui    = 7'b0110111,
        OpAuipc  = 7'b0010111
    } opcodeE;

    // instruction class, control unit to alu decoder
    typedef enum logic [2:0] {
        AluOpR      = 3'b000, // funct3/funct7 decide
        AluOpI      = 3'b001, // funct3 decides, funct7b5 only for srai
        AluOpLoad   = 3'b010, // address add
        AluOpStore  = 3'b011, // address add
        AluOpBranch = 3'b100, // subtract for flags
        AluOpJump   = 3'b101, // jal and jalr, add
        AluOpLui    = 3'b110, // pass immediate
        AluOpAuipc  = 3'b111
    } aluOpE;

    // alu operation select
    typedef enum logic [3:0] {
        AluAdd   = 4'd0,
        AluSub   = 4'd1,
        AluAnd   = 4'd2,
        AluOr    = 4'd3,
        AluXor   = 4'd4,
        AluSll   = 4'd5,
        AluSrl   = 4'd6,
        AluSra   = 4'd7,
        AluSlt   = 4'd8, // signed compare
        AluSltu  = 4'd9, // unsigned compare
        AluPassB = 4'd10 // lui
    } aluCtrlE;

    // immediate formats
    typedef enum logic [2:0] {
        ImmI = 3'b000,
        ImmS = 3'b001,
        ImmB = 3'b010,
        ImmU = 3'b011,
        ImmJ = 3'b100
    } immSrcE;

    // next pc select, 2'b10 unused
    typedef enum logic [1:0] {
        PcPlus4     = 2'b00,
        PcTarget    = 2'b01, // pc + imm
        PcAluResult = 2'b11  // jalr, bit 0 cleared in core
    } pcSrcE;

    // write-back select
    typedef enum logic [1:0] {
        ResAlu      = 2'b00,
        ResMem      = 2'b01,
        ResPcPlus4  = 2'b10, // link value
        ResPcTarget = 2'b11  // auipc
    } resultSrcE;

endpackage

/* rtl/ControlUnit.sv */
`timescale 1ns/1ns

module ControlUnit (
    input  rvPkg::opcodeE    opcode,       // instr[6:0]
    input  logic [2:0]       funct3,       // branch condition
    input  logic             zeroFlag,     // srcA == srcB
    input  logic             negativeFlag, // signed srcA < srcB
    input  logic             unsignedLess, // unsigned srcA < srcB
    output rvPkg::pcSrcE     pcSrc,
    output rvPkg::resultSrcE resultSrc,
    output logic             memWrite,
    output logic             aluSrc,       // 1 selects immediate
    output rvPkg::immSrcE    immSrc,
    output logic             regWrite,
    output rvPkg::aluOpE     aluOp         // to alu decoder
);

    logic branchTaken; // condition met for current funct3

    always_comb begin
        case (funct3)
            3'b000:  branchTaken = zeroFlag;      // beq
            3'b001:  branchTaken = ~zeroFlag;     // bne
            3'b100:  branchTaken = negativeFlag;  // blt
            3'b101:  branchTaken = ~negativeFlag; // bge
            3'b110:  branchTaken = unsignedLess;  // bltu
            3'b111:  branchTaken = ~unsignedLess; // bgeu
            default: branchTaken = 1'b0;          // 010/011 not branches
        endcase
    end

    always_comb begin
        // safe defaults, also what an unknown opcode gets
        pcSrc     = rvPkg::PcPlus4;
        resultSrc = rvPkg::ResAlu;
        memWrite  = 1'b0;
        aluSrc    = 1'b0;
        immSrc    = rvPkg::ImmI;
        regWrite  = 1'b0;
        aluOp     = rvPkg::AluOpR;
        case (opcode)
            rvPkg::OpRType: begin
                regWrite = 1'b1; // rs1 op rs2
            end
            rvPkg::OpIType: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                aluOp    = rvPkg::AluOpI;
            end
            rvPkg::OpLoad: begin
                aluSrc    = 1'b1;            // rs1 + offset
                regWrite  = 1'b1;
                resultSrc = rvPkg::ResMem;
                aluOp     = rvPkg::AluOpLoad;
            end
            rvPkg::OpStore: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
                immSrc   = rvPkg::ImmS;      // split offset
                aluOp    = rvPkg::AluOpStore;
            end
            rvPkg::OpBranch: begin
                immSrc = rvPkg::ImmB;        // alu compares rs1, rs2
                aluOp  = rvPkg::AluOpBranch;
                if (branchTaken) begin
                    pcSrc = rvPkg::PcTarget;
                end
            end
            rvPkg::OpJal: begin
                pcSrc     = rvPkg::PcTarget;
                resultSrc = rvPkg::ResPcPlus4; // link
                immSrc    = rvPkg::ImmJ;
                regWrite  = 1'b1;
                aluOp     = rvPkg::AluOpJump;
            end
            rvPkg::OpJalr: begin
                pcSrc     = rvPkg::PcAluResult; // rs1 + imm
                resultSrc = rvPkg::ResPcPlus4;
                aluSrc    = 1'b1;
                regWrite  = 1'b1;
                aluOp     = rvPkg::AluOpJump;
            end
            rvPkg::OpLui: begin
                aluSrc   = 1'b1;
                immSrc   = rvPkg::ImmU;
                regWrite = 1'b1;
                aluOp    = rvPkg::AluOpLui;
            end
            rvPkg::OpAuipc: begin
                resultSrc = rvPkg::ResPcTarget; // pc + upper imm
                aluSrc    = 1'b1;
                immSrc    = rvPkg::ImmU;
                regWrite  = 1'b1;
                aluOp     = rvPkg::AluOpAuipc;
            end
            default: ;
        endcase
    end

endmodule

/* rtl/AluDecoder.sv */
`timescale 1ns/1ns

module AluDecoder (
    input  rvPkg::aluOpE   aluOp,
    input  logic [2:0]     funct3,
    input  logic           funct7b5, // instr[30]
    output rvPkg::aluCtrlE aluCtrl
);

    logic isSub; // only R-type uses bit 30 for sub

    assign isSub = (aluOp == rvPkg::AluOpR) && funct7b5;

    always_comb begin
        case (aluOp)
            rvPkg::AluOpR,
            rvPkg::AluOpI: begin
                case (funct3)
                    3'b000:  aluCtrl = isSub ? rvPkg::AluSub : rvPkg::AluAdd; // addi stays add
                    3'b001:  aluCtrl = rvPkg::AluSll;
                    3'b010:  aluCtrl = rvPkg::AluSlt;
                    3'b011:  aluCtrl = rvPkg::AluSltu;
                    3'b100:  aluCtrl = rvPkg::AluXor;
                    3'b101:  aluCtrl = funct7b5 ? rvPkg::AluSra : rvPkg::AluSrl; // srai too
                    3'b110:  aluCtrl = rvPkg::AluOr;
                    default: aluCtrl = rvPkg::AluAnd; // 111
                endcase
            end
            rvPkg::AluOpLoad,
            rvPkg::AluOpStore,
            rvPkg::AluOpJump,
            rvPkg::AluOpAuipc: begin
                aluCtrl = rvPkg::AluAdd; // address / target arithmetic
            end
            rvPkg::AluOpBranch: begin
                aluCtrl = rvPkg::AluSub; // flags only
            end
            rvPkg::AluOpLui: begin
                aluCtrl = rvPkg::AluPassB;
            end
            default: begin
                aluCtrl = rvPkg::AluAdd;
            end
        endcase
    end

endmodule

/* rtl/Alu.sv */
`timescale 1ns/1ns

module Alu (
    input  logic [31:0]    srcA,
    input  logic [31:0]    srcB,
    input  rvPkg::aluCtrlE aluCtrl,
    output logic [31:0]    aluResult,
    output logic           zeroFlag,     // srcA - srcB == 0
    output logic           negativeFlag, // signed less-than
    output logic           unsignedLess  // borrow out
);

    logic [32:0] diffWide; // extra bit catches the borrow
    logic [31:0] diff;
    logic        overflow; // signed overflow of the subtract
    logic [4:0]  shamt;

    assign diffWide = {1'b0, srcA} - {1'b0, srcB};
    assign diff     = diffWide[31:0];
    assign overflow = (srcA[31] ^ srcB[31]) & (diff[31] ^ srcA[31]);
    assign shamt    = srcB[4:0]; // rv32 uses low five bits

    // flags come from the subtract whatever the selected op
    assign zeroFlag     = (diff == 32'd0);
    assign negativeFlag = diff[31] ^ overflow; // sign fixed up on overflow
    assign unsignedLess = diffWide[32];

    always_comb begin
        case (aluCtrl)
            rvPkg::AluAdd:   aluResult = srcA + srcB;
            rvPkg::AluSub:   aluResult = diff;
            rvPkg::AluAnd:   aluResult = srcA & srcB;
            rvPkg::AluOr:    aluResult = srcA | srcB;
            rvPkg::AluXor:   aluResult = srcA ^ srcB;
            rvPkg::AluSll:   aluResult = srcA << shamt;
            rvPkg::AluSrl:   aluResult = srcA >> shamt;
            rvPkg::AluSra:   aluResult = $signed(srcA) >>> shamt; // sign fill
            rvPkg::AluSlt:   aluResult = {31'd0, negativeFlag};
            rvPkg::AluSltu:  aluResult = {31'd0, unsignedLess};
            rvPkg::AluPassB: aluResult = srcB; // lui
            default:         aluResult = 32'd0;
        endcase
    end

endmodule

/* rtl/RegisterFile.sv */
`timescale 1ns/1ns

module RegisterFile (
    input  logic        clk,
    input  logic        arstN,
    input  logic [4:0]  readAddr1,  // rs1
    input  logic [4:0]  readAddr2,  // rs2
    input  logic [4:0]  writeAddr,  // rd
    input  logic        writeEnable,
    input  logic [31:0] writeData,
    output logic [31:0] readData1,
    output logic [31:0] readData2
);

    logic [31:0] regs [32]; // x0 kept at zero by never writing it

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (writeEnable && (writeAddr != 5'd0)) begin
            regs[writeAddr] <= writeData; // x0 writes dropped
        end
    end

    // combinational reads, same-cycle write not forwarded
    assign readData1 = regs[readAddr1];
    assign readData2 = regs[readAddr2];

    // x0 reads zero on both ports after any write history
    x0ReadsZero: assert property (@(posedge clk) disable iff (!arstN)
        ((readAddr1 == 5'd0) |-> (readData1 == 32'd0)) and
        ((readAddr2 == 5'd0) |-> (readData2 == 32'd0)));

endmodule

/* rtl/ImmExtend.sv */
`timescale 1ns/1ns

module ImmExtend (
    input  logic [31:7]   instrBits, // keeps instr bit numbering
    input  rvPkg::immSrcE immSrc,
    output logic [31:0]   immExt
);

    logic signBit;

    assign signBit = instrBits[31]; // all formats sign from bit 31

    always_comb begin
        case (immSrc)
            rvPkg::ImmI: immExt = {{20{signBit}}, instrBits[31:20]};
            rvPkg::ImmS: immExt = {{20{signBit}}, instrBits[31:25], instrBits[11:7]};
            rvPkg::ImmB: begin
                immExt = {{19{signBit}}, signBit, instrBits[7],
                          instrBits[30:25], instrBits[11:8], 1'b0}; // halfword offset
            end
            rvPkg::ImmU: immExt = {instrBits[31:12], 12'd0}; // upper 20
            rvPkg::ImmJ: begin
                immExt = {{11{signBit}}, signBit, instrBits[19:12],
                          instrBits[20], instrBits[30:21], 1'b0};
            end
            default: immExt = 32'd0;
        endcase
    end

endmodule

/* rtl/RiscvCore.sv */
`timescale 1ns/1ns

module RiscvCore #(
    parameter logic [31:0] ResetPc = 32'h0000_0000 // first fetch address
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic [31:0] instr,     // imem read at pc
    input  logic [31:0] readData,  // dmem read at dataAddr
    output logic [31:0] pc,
    output logic [31:0] dataAddr,
    output logic [31:0] writeData,
    output logic        memWrite
);

    rvPkg::opcodeE    opcode;
    rvPkg::pcSrcE     pcSrc;
    rvPkg::resultSrcE resultSrc;
    rvPkg::immSrcE    immSrc;
    rvPkg::aluOpE     aluOp;
    rvPkg::aluCtrlE   aluCtrl;

    logic        ctrlMemWrite; // ungated decoder outputs
    logic        ctrlRegWrite;
    logic        aluSrc;
    logic        runEn;        // low until first edge after reset
    logic        zeroFlag;
    logic        negativeFlag;
    logic        unsignedLess;
    logic [31:0] immExt;
    logic [31:0] readData1;
    logic [31:0] readData2;
    logic [31:0] srcB;
    logic [31:0] aluResult;
    logic [31:0] result;       // write-back value
    logic [31:0] pcPlus4;
    logic [31:0] pcTarget;
    logic [31:0] pcNext;

    assign opcode = rvPkg::opcodeE'(instr[6:0]);

    // holds the core idle for the partial cycle in which reset is released
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            runEn <= 1'b0;
        end else begin
            runEn <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= ResetPc;
        end else if (runEn) begin
            pc <= pcNext; // one instruction per edge
        end
    end

    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + immExt; // branch, jal, auipc

    always_comb begin
        case (pcSrc)
            rvPkg::PcTarget:    pcNext = pcTarget;
            rvPkg::PcAluResult: pcNext = {aluResult[31:1], 1'b0}; // jalr clears bit 0
            default:            pcNext = pcPlus4;
        endcase
    end

    always_comb begin
        case (resultSrc)
            rvPkg::ResMem:      result = readData;
            rvPkg::ResPcPlus4:  result = pcPlus4;
            rvPkg::ResPcTarget: result = pcTarget;
            default:            result = aluResult;
        endcase
    end

    assign srcB      = aluSrc ? immExt : readData2;
    assign dataAddr  = aluResult;             // lw/sw address
    assign writeData = readData2;             // sw data from rs2
    assign memWrite  = ctrlMemWrite & runEn;

    ControlUnit control_i (
        .opcode       (opcode),
        .funct3       (instr[14:12]),
        .zeroFlag     (zeroFlag),
        .negativeFlag (negativeFlag),
        .unsignedLess (unsignedLess),
        .pcSrc        (pcSrc),
        .resultSrc    (resultSrc),
        .memWrite     (ctrlMemWrite),
        .aluSrc       (aluSrc),
        .immSrc       (immSrc),
        .regWrite     (ctrlRegWrite),
        .aluOp        (aluOp)
    );

    AluDecoder decoder_i (
        .aluOp    (aluOp),
        .funct3   (instr[14:12]),
        .funct7b5 (instr[30]),
        .aluCtrl  (aluCtrl)
    );

    Alu alu_i (
        .srcA         (readData1),
        .srcB         (srcB),
        .aluCtrl      (aluCtrl),
        .aluResult    (aluResult),
        .zeroFlag     (zeroFlag),
        .negativeFlag (negativeFlag),
        .unsignedLess (unsignedLess)
    );

    RegisterFile regFile_i (
        .clk         (clk),
        .arstN       (arstN),
        .readAddr1   (instr[19:15]),
        .readAddr2   (instr[24:20]),
        .writeAddr   (instr[11:7]),
        .writeEnable (ctrlRegWrite & runEn),
        .writeData   (result),
        .readData1   (readData1),
        .readData2   (readData2)
    );

    ImmExtend immExt_i (
        .instrBits (instr[31:7]),
        .immSrc    (immSrc),
        .immExt    (immExt)
    );

    // catches misaligned branch/jump targets from the program
    pcAligned: assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00);

endmodule

/* testbench/RiscvCoreTb.sv */
`timescale 1ns/1ns

module RiscvCoreTb;

    localparam logic [31:0] ResetPc   = 32'h0000_0000;
    localparam int          MaxCycles = 80;                  // per program run
    localparam logic [31:0] Halt      = 32'h0000_006f;       // jal x0, 0 self-loop
    localparam logic [39:0] ROpList   = 40'h01_24_68_ab_ce;  // {funct3, bit30} per op
    localparam logic [39:0] IOpList   = 40'h02_46_8a_bc_e0;  // last one is negative addi
    localparam logic [35:0] BrF3      = 36'o00_11_44_55_66_77; // each branch twice

    logic        clk;
    logic        arstN;
    logic [31:0] instr;
    logic [31:0] readData;
    logic [31:0] pc;
    logic [31:0] dataAddr;
    logic [31:0] writeData;
    logic        memWrite;
    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] storeAddrQ [$]; // stores seen at the clock edge
    logic [31:0] storeDataQ [$];
    logic [31:0] pcTrace [$];    // pc of each executed cycle
    logic [31:0] expTrace [$];
    int          progLen;
    int          errorCount;
    int          checkCount;
    int          testCount;

    RiscvCore #(.ResetPc(ResetPc)) dut_i (
        .clk       (clk),
        .arstN     (arstN),
        .instr     (instr),
        .readData  (readData),
        .pc        (pc),
        .dataAddr  (dataAddr),
        .writeData (writeData),
        .memWrite  (memWrite)
    );

    assign instr    = imem[pc[9:2]];       // combinational fetch, 1 KB
    assign readData = dmem[dataAddr[9:2]];

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (memWrite) begin
            dmem[dataAddr[9:2]] <= writeData;
            storeAddrQ.push_back(dataAddr);
            storeDataQ.push_back(writeData);
        end
    end

    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return ~addr ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rvPkg::OpRType};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2, rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvPkg::OpStore}; // sw
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvPkg::OpBranch};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvPkg::OpJal};
    endfunction

    // rv32i result rules, alt is instr bit 30 where the op uses it
    function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0]; // sign fill
                end
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchModel(input logic [2:0] f3, input logic [31:0] a, b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // operands per branch case, even k taken and odd k not
    function automatic logic [63:0] brPair(input int k, input logic [31:0] r);
        case (k)
            0:       return {r, r};
            1:       return {r, r ^ 32'h8000_0000};
            2:       return {32'h8000_0000, 32'h7fff_ffff};
            3:       return {r, r};
            4:       return {32'hffff_ffff, 32'h0000_0001}; // -1 < 1
            5:       return {32'h0000_0001, 32'hffff_ffff};
            6:       return {32'h7fff_ffff, 32'h8000_0000};
            7:       return {32'hffff_fffe, 32'hffff_ffff};
            8:       return {32'h0000_0000, 32'hffff_ffff};
            9:       return {32'hffff_ffff, 32'h0000_0000};
            10:      return {32'hffff_ffff, 32'hffff_ffff};
            default: return {32'h0000_0000, 32'h0000_0001};
        endcase
    endfunction

    task automatic checkWord(input string name, input logic [31:0] exp, got);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic checkPc(input string name, input logic [31:0] exp, got);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic checkStore(input logic [31:0] expAddr, expData);
        logic [31:0] gotAddr;
        logic [31:0] gotData;
        checkCount++;
        if (storeAddrQ.size() == 0) begin
            errorCount++;
            $display("Error at %0t ns: no store to %h happened", $time, expAddr);
            return;
        end
        gotAddr = storeAddrQ.pop_front();
        gotData = storeDataQ.pop_front();
        if (gotAddr !== expAddr || gotData !== expData) begin
            errorCount++;
            $display("Mismatch at %0t ns: dataAddr/writeData expected %h/%h, got %h/%h",
                     $time, expAddr, expData, gotAddr, gotData);
        end
    endtask

    task automatic checkTrace();
        checkCount++;
        if (pcTrace.size() != expTrace.size()) begin
            errorCount++;
            $display("Error at %0t ns: program ran %0d cycles instead of %0d",
                     $time, pcTrace.size(), expTrace.size());
        end
        for (int i = 0; i < pcTrace.size() && i < expTrace.size(); i++) begin
            checkPc($sformatf("pc[%0d]", i), expTrace[i], pcTrace[i]);
        end
    endtask

    task automatic clearMemories();
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'd0;                     // opcode 0 decodes as a no-op
            dmem[i] = fillWord(32'(i) << 2);
        end
    endtask

    task automatic emit(input logic [31:0] word);
        imem[progLen] = word;
        progLen++;
    endtask

    task automatic emitLi(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] upper;
        upper = v + 32'h800; // addi sign-extends the low 12 bits
        emit(encU(upper[31:12], rd, rvPkg::OpLui));
        emit(encI(v[11:0], rd, 3'b000, rd, rvPkg::OpIType));
    endtask

    task automatic startProgram();
        @(posedge clk);
        #5 arstN = 1'b0;
        clearMemories();
        storeAddrQ.delete();
        storeDataQ.delete();
        pcTrace.delete();
        expTrace.delete();
        progLen = 0;
    endtask

    // holds reset 3 cycles, releases it, then records pc until the halt loop
    task automatic runProgram();
        bit halted;
        halted = 1'b0;
        repeat (3) begin
            @(negedge clk);
            checkPc("pc in reset", ResetPc, pc);
            checkWord("memWrite in reset", 32'd0, {31'd0, memWrite});
        end
        @(posedge clk);
        #5 arstN = 1'b1;
        @(posedge clk); // core armed here, first instruction follows
        for (int c = 0; c < MaxCycles && !halted; c++) begin
            @(negedge clk);
            pcTrace.push_back(pc);
            halted = (instr == Halt);
        end
        if (!halted) begin
            errorCount++;
            $display("Error at %0t ns: program never reached its halt loop", $time);
        end
    endtask

    task automatic endTest(input string name, input int errorsBefore);
        if (storeAddrQ.size() != 0) begin
            errorCount++;
            $display("Error at %0t ns: %0d extra stores happened", $time, storeAddrQ.size());
        end
        testCount++;
        $display("test %s %s", name, (errorCount == errorsBefore) ? "passed" : "failed");
    endtask

    task automatic resetTest();
        int errorsBefore;
        errorsBefore = errorCount;
        startProgram();
        emit(encS(12'd256, 5'd0, 5'd0)); // would show as a store if not gated in reset
        for (int i = 1; i < 6; i++) begin
            emit(encI(12'(i), 5'd0, 3'b000, 5'(i), rvPkg::OpIType));
        end
        emit(Halt);
        runProgram();
        for (int i = 0; i < 7; i++) begin
            expTrace.push_back(ResetPc + 32'(4 * i));
        end
        checkTrace();
        checkStore(32'd256, 32'd0);
        endTest("reset", errorsBefore);
    endtask

    task automatic aluTest();
        int          errorsBefore;
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        logic [31:0] expQ [$];
        errorsBefore = errorCount;
        startProgram();
        a = $urandom();
        b = $urandom();
        emitLi(5'd1, a);
        emitLi(5'd2, b);
        for (int k = 0; k < 10; k++) begin
            {f3, alt} = ROpList[4 * (9 - k) +: 4];
            emit(encR(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3));
            emit(encS(12'(256 + 4 * k), 5'd3, 5'd0));
            expQ.push_back(aluModel(f3, alt, a, b));
        end
        for (int k = 0; k < 10; k++) begin
            {f3, alt} = IOpList[4 * (9 - k) +: 4];
            imm = 12'($urandom());
            if (f3 == 3'b001 || f3 == 3'b101) begin
                imm = {1'b0, alt, 5'd0, imm[4:0]}; // shamt, bit 30 picks srai
            end
            if (k == 9) begin
                imm[11:10] = 2'b11;                 // negative addi, bit 30 set
            end
            emit(encI(imm, 5'd1, f3, 5'd3, rvPkg::OpIType));
            emit(encS(12'(296 + 4 * k), 5'd3, 5'd0));
            expQ.push_back(aluModel(f3, alt, a, {{20{imm[11]}}, imm}));
        end
        emit(Halt);
        runProgram();
        for (int k = 0; k < 20; k++) begin
            checkStore(32'(256 + 4 * k), expQ[k]);
        end
        endTest("alu", errorsBefore);
    endtask

    task automatic memTest();
        int          errorsBefore;
        logic [31:0] v;
        errorsBefore = errorCount;
        startProgram();
        v = $urandom();
        emitLi(5'd1, v);
        emit(encS(12'd260, 5'd1, 5'd0));
        emit(encI(12'd260, 5'd0, 3'b010, 5'd2, rvPkg::OpLoad)); // read back
        emit(encS(12'd264, 5'd2, 5'd0));
        emit(encI(12'd512, 5'd0, 3'b010, 5'd3, rvPkg::OpLoad)); // untouched fill word
        emit(encS(12'd268, 5'd3, 5'd0));
        emit(Halt);
        runProgram();
        checkStore(32'd260, v);
        checkStore(32'd264, v);
        checkStore(32'd268, fillWord(32'd512));
        checkWord("dmem[264]", v, dmem[66]);
        endTest("memory", errorsBefore);
    endtask

    task automatic branchTest();
        int          errorsBefore;
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        errorsBefore = errorCount;
        for (int k = 0; k < 12; k++) begin
            f3 = BrF3[3 * (11 - k) +: 3];
            {a, b} = brPair(k, $urandom());
            startProgram();
            emitLi(5'd1, a);
            emitLi(5'd2, b);
            emit(encB(13'd8, 5'd2, 5'd1, f3));  // at 16, skips the addi when taken
            emit(encI(12'd1, 5'd0, 3'b000, 5'd3, rvPkg::OpIType));
            emit(Halt);
            runProgram();
            for (int i = 0; i < 5; i++) begin
                expTrace.push_back(ResetPc + 32'(4 * i));
            end
            if (!branchModel(f3, a, b)) begin
                expTrace.push_back(32'd20);
            end
            expTrace.push_back(32'd24);
            checkTrace();
        end
        endTest("branch", errorsBefore);
    endtask

    task automatic jumpTest();
        int          errorsBefore;
        logic [19:0] u1;
        logic [19:0] u2;
        logic [31:0] jt;
        errorsBefore = errorCount;
        startProgram();
        u1 = 20'($urandom());
        u2 = 20'($urandom());
        emit(encJ(21'd16, 5'd1));                                // 0: jal x1, +16
        emit(encI(12'd99, 5'd0, 3'b000, 5'd9, rvPkg::OpIType)); // 4: skipped
        emit(encS(12'd300, 5'd9, 5'd0));                        // 8: skipped
        emit(Halt);                                             // 12
        emit(encI(12'd35, 5'd0, 3'b000, 5'd2, rvPkg::OpIType)); // 16: x2 = 35
        emit(encI(12'd2, 5'd2, 3'b000, 5'd3, rvPkg::OpJalr));   // 20: odd target 37
        progLen = 9;                                            // 24..32 stay zero
        emit(encS(12'd256, 5'd1, 5'd0));
        emit(encS(12'd260, 5'd3, 5'd0));
        emit(encU(u1, 5'd4, rvPkg::OpLui));
        emit(encS(12'd264, 5'd4, 5'd0));
        emit(encU(u2, 5'd5, rvPkg::OpAuipc));                   // at 52
        emit(encS(12'd268, 5'd5, 5'd0));
        emit(Halt);
        runProgram();
        jt = (32'd35 + 32'd2) & ~32'd1;
        expTrace.push_back(32'd0);
        expTrace.push_back(32'd16);
        expTrace.push_back(32'd20);
        for (int i = 0; i < 7; i++) begin
            expTrace.push_back(jt + 32'(4 * i));
        end
        checkTrace();
        checkStore(32'd256, 32'd4);  // jal link
        checkStore(32'd260, 32'd24); // jalr link
        checkStore(32'd264, {u1, 12'd0});
        checkStore(32'd268, 32'd52 + {u2, 12'd0});
        endTest("jump", errorsBefore);
    endtask

    task automatic zeroRegTest();
        int          errorsBefore;
        logic [31:0] v;
        errorsBefore = errorCount;
        startProgram();
        v = $urandom() | 32'h0000_1001; // nonzero in both halves
        emitLi(5'd1, v);
        emit(encI(v[11:0], 5'd0, 3'b000, 5'd0, rvPkg::OpIType)); // addi x0
        emit(encS(12'd256, 5'd0, 5'd0));
        emit(encR(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));              // add x0
        emit(encS(12'd260, 5'd0, 5'd0));
        emit(encU(v[31:12], 5'd0, rvPkg::OpLui));                 // lui x0
        emit(encS(12'd264, 5'd0, 5'd0));
        emit(Halt);
        runProgram();
        checkStore(32'd256, 32'd0);
        checkStore(32'd260, 32'd0);
        checkStore(32'd264, 32'd0);
        endTest("x0", errorsBefore);
    endtask

    initial begin
        clk        = 1'b0;
        arstN      = 1'b0;
        progLen    = 0;
        errorCount = 0;
        checkCount = 0;
        testCount  = 0;
        clearMemories();
        void'($urandom(32'h8469));
        resetTest();
        aluTest();
        memTest();
        branchTest();
        jumpTest();
        zeroRegTest();
        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // 6 tests x 80 cycles x 100 ns, doubled
    initial begin
        #(6 * MaxCycles * 100 * 2);
        $display("Error: simulation hung, no result after %0d ns", 6 * MaxCycles * 100 * 2);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* RiscvCore.f */
rtl/rvPkg.sv
rtl/ControlUnit.sv
rtl/AluDecoder.sv
rtl/Alu.sv
rtl/RegisterFile.sv
rtl/ImmExtend.sv
rtl/RiscvCore.sv
testbench/RiscvCoreTb.sv
